/* hdl/isaPkg.sv */
package isaPkg;

   // Instruction or data word
   typedef logic [31:0] wordT;

   // Major opcode, top six bits of the word
   typedef logic [5:0] opcodeT;

   // Register index for rd, ra and rb
   typedef logic [4:0] regAddrT;

   // Low half of the instruction, also the immediate
   typedef logic [15:0] immT;

   // Function bits below the rb field
   typedef logic [10:0] altT;

   // IMM prefix, upper half for the next immediate
   localparam opcodeT opImm  = 6'o54;
   // Return from subroutine, has a delay slot
   localparam opcodeT opRtd  = 6'o55;
   // Unconditional branch, register and immediate forms
   localparam opcodeT opBr   = 6'o46;
   localparam opcodeT opBri  = 6'o56;
   // Conditional branch, register and immediate forms
   localparam opcodeT opBcc  = 6'o47;
   localparam opcodeT opBcci = 6'o57;

   // Size of the general register file
   localparam int regCount = 32;

endpackage

/* hdl/fetchPkg.sv */
package fetchPkg;

   // Branch forced into the stream on an interrupt
   // Opcode bri, ra field sets absolute and link
   // Return address goes to r14, target is 0x60
   localparam isaPkg::wordT intBranch = {
      isaPkg::opBri,
      5'd14,
      5'h0c,
      16'h0060
   };

   // Sampling stages on the raw interrupt level
   // First stage feeds the pending flag
   localparam int syncDepth = 2;

endpackage

/* hdl/intLatch.sv */
module intLatch (
   input  logic gclk,
   input  logic grst,
   // Interrupt enable from the status register
   input  logic msrIe,
   // Raw level, not related to gclk
   input  logic sysInt,
   // Injection has loaded into the buffer
   input  logic intAck,
   output logic intPending
);

   // Sampling chain, newest sample in bit 0
   logic [fetchPkg::syncDepth-1:0] intSync;

   // Level seen by the first stage
   logic intShot;

   assign intShot = intSync[0];

   // Runs every edge, independent of decode enable
   // so a stall never loses a request
   always_ff @(posedge gclk) begin
      if (grst) begin
         intSync    <= '0;
         intPending <= 1'b0;
      end else begin
         // Sample only while interrupts are enabled
         if (msrIe) begin
            intSync <= {intSync[fetchPkg::syncDepth-2:0], sysInt};
         end

         // Acknowledge wins over a new sample
         if (intAck) begin
            intPending <= 1'b0;
         end else begin
            // Sticky until taken, dropped if enable goes low
            intPending <= (intPending | intShot) & msrIe;
         end
      end
   end

endmodule

/* hdl/instBuf.sv */
module instBuf (
   input  logic             gclk,
   input  logic             grst,
   // Decode enable, low holds the pipeline register
   input  logic             dEn,
   input  isaPkg::wordT     iWord,
   input  logic             intPending,
   // Registered fields
   output isaPkg::opcodeT   opc,
   output isaPkg::regAddrT  rd,
   output isaPkg::regAddrT  ra,
   output isaPkg::regAddrT  rb,
   output isaPkg::altT      alt,
   output isaPkg::immT      imm,
   output isaPkg::wordT     sImm,
   // Register file addresses of the current word
   output isaPkg::regAddrT  rdAddrA,
   output isaPkg::regAddrT  rdAddrB,
   output isaPkg::regAddrT  rdAddrD,
   output logic             intAck
);

   // Classes of the registered opcode
   logic prevImm;
   logic prevRtd;
   logic prevBru;
   logic prevBcc;

   // Injection is legal this cycle
   logic blockInt;
   logic doInject;

   // Word chosen for decode and its extended immediate
   isaPkg::wordT curWord;
   isaPkg::wordT curSImm;

   assign prevImm = (opc == isaPkg::opImm);
   assign prevRtd = (opc == isaPkg::opRtd);
   assign prevBru = (opc == isaPkg::opBr) || (opc == isaPkg::opBri);
   assign prevBcc = (opc == isaPkg::opBcc) || (opc == isaPkg::opBcci);

   // Never split a prefix from its instruction
   // and never take a delay slot away from a branch
   assign blockInt = prevImm | prevRtd | prevBru | prevBcc;
   assign doInject = intPending & ~blockInt;

   always_comb begin
      if (doInject) begin
         curWord = fetchPkg::intBranch;
      end else begin
         curWord = iWord;
      end
   end

   // Prefix supplies the upper half after an IMM
   always_comb begin
      if (prevImm) begin
         curSImm = {imm, curWord[15:0]};
      end else begin
         curSImm = {{16{curWord[15]}}, curWord[15:0]};
      end
   end

   // Read addresses go out unregistered
   assign rdAddrD = curWord[25:21];
   assign rdAddrA = curWord[20:16];
   assign rdAddrB = curWord[15:11];

   // rb and alt share the low half
   assign rb  = imm[15:11];
   assign alt = imm[10:0];

   always_ff @(posedge gclk) begin
      if (grst) begin
         opc    <= '0;
         rd     <= '0;
         ra     <= '0;
         imm    <= '0;
         sImm   <= '0;
         intAck <= 1'b0;
      end else if (dEn) begin
         opc    <= curWord[31:26];
         rd     <= curWord[25:21];
         ra     <= curWord[20:16];
         imm    <= curWord[15:0];
         sImm   <= curSImm;
         // High only for the edge that took the branch
         intAck <= doInject;
      end
   end

endmodule

/* hdl/operandFetch.sv */
module operandFetch (
   input  logic             gclk,
   input  logic             grst,
   // Same enable as the field register
   input  logic             load,
   input  isaPkg::regAddrT  rdAddrA,
   input  isaPkg::regAddrT  rdAddrB,
   input  isaPkg::regAddrT  rdAddrD,
   // Writeback port
   input  logic             wrEn,
   input  isaPkg::regAddrT  wrAddr,
   input  isaPkg::wordT     wrData,
   output isaPkg::wordT     opA,
   output isaPkg::wordT     opB,
   output isaPkg::wordT     opD
);

   // General registers, r0 kept but never read
   isaPkg::wordT regFile [isaPkg::regCount];

   // One read port with r0 and writeback bypass
   function automatic isaPkg::wordT readReg(input isaPkg::regAddrT addr);
      isaPkg::wordT val;
      if (addr == '0) begin
         val = '0;
      end else if (wrEn && (wrAddr == addr)) begin
         // Write lands this edge, hand it straight over
         val = wrData;
      end else begin
         val = regFile[addr];
      end
      return val;
   endfunction

   // Writeback ignores decode enable
   always_ff @(posedge gclk) begin
      if (wrEn) begin
         regFile[wrAddr] <= wrData;
      end
   end

   // Operands line up with the buffered fields
   always_ff @(posedge gclk) begin
      if (grst) begin
         opA <= '0;
         opB <= '0;
         opD <= '0;
      end else if (load) begin
         opA <= readReg(rdAddrA);
         opB <= readReg(rdAddrB);
         opD <= readReg(rdAddrD);
      end
   end

endmodule

/* hdl/fetchFront.sv */
module fetchFront (
   input  logic             gclk,
   input  logic             grst,
   input  logic             dEn,
   input  isaPkg::wordT     iWord,
   input  logic             msrIe,
   input  logic             sysInt,
   // Writeback from later stages
   input  logic             wrEn,
   input  isaPkg::regAddrT  wrAddr,
   input  isaPkg::wordT     wrData,
   // Decoded fields
   output isaPkg::opcodeT   opc,
   output isaPkg::regAddrT  rd,
   output isaPkg::regAddrT  ra,
   output isaPkg::regAddrT  rb,
   output isaPkg::altT      alt,
   output isaPkg::immT      imm,
   output isaPkg::wordT     sImm,
   // Operands for the same instruction
   output isaPkg::wordT     opA,
   output isaPkg::wordT     opB,
   output isaPkg::wordT     opD,
   output logic             intAck
);

   // Latch to buffer
   logic intPending;

   // Buffer to register file
   isaPkg::regAddrT rdAddrA;
   isaPkg::regAddrT rdAddrB;
   isaPkg::regAddrT rdAddrD;

   // Interrupt request, free running
   intLatch intLatch_i (
      .gclk       (gclk),
      .grst       (grst),
      .msrIe      (msrIe),
      .sysInt     (sysInt),
      .intAck     (intAck),
      .intPending (intPending)
   );

   // Word select and field register
   instBuf instBuf_i (
      .gclk       (gclk),
      .grst       (grst),
      .dEn        (dEn),
      .iWord      (iWord),
      .intPending (intPending),
      .opc        (opc),
      .rd         (rd),
      .ra         (ra),
      .rb         (rb),
      .alt        (alt),
      .imm        (imm),
      .sImm       (sImm),
      .rdAddrA    (rdAddrA),
      .rdAddrB    (rdAddrB),
      .rdAddrD    (rdAddrD),
      .intAck     (intAck)
   );

   // Operand read, loads with the fields
   operandFetch operandFetch_i (
      .gclk    (gclk),
      .grst    (grst),
      .load    (dEn),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .rdAddrD (rdAddrD),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .opA     (opA),
      .opB     (opB),
      .opD     (opD)
   );

endmodule

/* dv/tbClock.sv */
module tbClock (
   output logic gclk,
   output logic grst
);

   timeunit 1ns;
   timeprecision 100ps;

   // 20 ns period
   initial begin
      gclk = 1'b0;
      forever #10 gclk = ~gclk;
   end

   // Reset held for eight rising edges
   initial begin
      grst = 1'b1;
      repeat (8) @(posedge gclk);
      grst <= 1'b0;
   end

endmodule

/* dv/fetchFront_assertions.sv */
module fetchFrontAssertions (
   input logic            gclk,
   input logic            grst,
   input logic            dEn,
   input logic            msrIe,
   input logic            intAck,
   input logic            intPending,
   input isaPkg::opcodeT  opc
);

   timeunit 1ns;
   timeprecision 100ps;

   // Injected branch blocks a second injection
   ackSingle: assert property (@(posedge gclk) disable iff (grst)
      (intAck && dEn) |=> !intAck)
      else $error("intAck high on two loading edges in a row");

   // Field register holds under a stall
   opcHold: assert property (@(posedge gclk) disable iff (grst)
      !dEn |=> $stable(opc))
      else $error("opc changed with dEn low");

   // Disabled interrupts drop the request
   pendClear: assert property (@(posedge gclk) disable iff (grst)
      !msrIe |=> !intPending)
      else $error("intPending set after msrIe low");

endmodule

bind fetchFront fetchFrontAssertions asrt_i (
   .gclk       (gclk),
   .grst       (grst),
   .dEn        (dEn),
   .msrIe      (msrIe),
   .intAck     (intAck),
   .intPending (intPending),
   .opc        (opc)
);

/* dv/fetchFrontTb.sv */
module fetchFrontTb;

   timeunit 1ns;
   timeprecision 100ps;

   logic gclk;
   logic grst;
   logic dEn;
   logic msrIe;
   logic sysInt;
   logic wrEn;
   isaPkg::regAddrT wrAddr;
   isaPkg::wordT wrData;
   isaPkg::wordT iWord;
   isaPkg::opcodeT opc;
   isaPkg::regAddrT rd;
   isaPkg::regAddrT ra;
   isaPkg::regAddrT rb;
   isaPkg::altT alt;
   isaPkg::immT imm;
   isaPkg::wordT sImm;
   isaPkg::wordT opA;
   isaPkg::wordT opB;
   isaPkg::wordT opD;
   logic intAck;

   // Trace rows, 17 hex columns after the test name
   logic [127:0] testName [64];
   logic [31:0] col [64][17];
   int lineCount = 0;
   int cycleLimit = 0;
   int cycles = 0;
   int checks = 0;
   int errors = 0;
   int testErrs = 0;
   int testsRun = 0;
   int testsFailed = 0;
   logic loaded = 1'b0;

   tbClock clk_i (
      .gclk (gclk),
      .grst (grst)
   );

   fetchFront dut_i (.*);

   // Reads the trace, skipping comment lines
   task automatic loadTrace();
      int fd;
      int n;
      string line;
      logic [127:0] nm;
      logic [31:0] v [17];
      fd = $fopen("dv/fetchFront_trace.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && lineCount < 64) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) != "#") begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  nm, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                  v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
               if (n == 18) begin
                  testName[lineCount] = nm;
                  for (int c = 0; c < 17; c++) begin
                     col[lineCount][c] = v[c];
                  end
                  lineCount++;
               end
            end
         end
         $fclose(fd);
         loaded = (lineCount > 0);
      end
   endtask

   task automatic driveRow(input int i);
      dEn    <= col[i][0][0];
      msrIe  <= col[i][1][0];
      sysInt <= col[i][2][0];
      wrEn   <= col[i][3][0];
      wrAddr <= col[i][4][4:0];
      wrData <= col[i][5];
      iWord  <= col[i][6];
   endtask

   task automatic compareValue(input string sig, input logic [31:0] exp,
                               input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         testErrs++;
         $display("FAIL %s expected %h got %h", sig, exp, act);
      end
   endtask

   // rb and alt are the upper and lower parts of imm
   task automatic checkRow(input int i);
      logic [15:0] expImm;
      expImm = col[i][10][15:0];
      compareValue("opc", col[i][7], 32'(opc));
      compareValue("rd", col[i][8], 32'(rd));
      compareValue("ra", col[i][9], 32'(ra));
      compareValue("imm", 32'(expImm), 32'(imm));
      compareValue("rb", 32'(expImm[15:11]), 32'(rb));
      compareValue("alt", 32'(expImm[10:0]), 32'(alt));
      compareValue("sImm", col[i][11], sImm);
      compareValue("intAck", col[i][16], 32'(intAck));
      if (col[i][12][0]) begin
         compareValue("opA", col[i][13], opA);
         compareValue("opB", col[i][14], opB);
         compareValue("opD", col[i][15], opD);
      end
   endtask

   // End of a test when the next row names another one
   task automatic closeTest(input int i);
      if (i == lineCount - 1 || testName[i + 1] != testName[i]) begin
         testsRun++;
         if (testErrs == 0) begin
            $display("test %0s done, no errors", testName[i]);
         end else begin
            testsFailed++;
            $display("test %0s done, %0d errors", testName[i], testErrs);
         end
         testErrs = 0;
      end
   endtask

   // Run limit from the trace length, reset and margin
   always @(posedge gclk) begin
      cycles <= cycles + 1;
      if (cycleLimit > 0 && cycles >= cycleLimit) begin
         $display("Timeout after %0d cycles, trace did not finish", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      dEn    = 1'b0;
      msrIe  = 1'b0;
      sysInt = 1'b0;
      wrEn   = 1'b0;
      wrAddr = '0;
      wrData = '0;
      iWord  = '0;
      loadTrace();
      if (!loaded) begin
         $display("Trace file missing or empty, nothing was run");
         $display("Checks failed");
      end else begin
         cycleLimit = lineCount + 8 + 20;
         // First edge always falls inside reset
         @(posedge gclk);
         while (grst) @(posedge gclk);
         // Row i loads on the edge after it is driven
         for (int i = 0; i <= lineCount; i++) begin
            @(posedge gclk);
            if (i < lineCount) begin
               driveRow(i);
            end
            if (i > 0) begin
               @(negedge gclk);
               checkRow(i - 1);
               closeTest(i - 1);
            end
         end
         $display("%0d tests, %0d failed, %0d checks, %0d errors",
                  testsRun, testsFailed, checks, errors);
         if (errors == 0) begin
            $display("All checks passed");
         end else begin
            $display("Checks failed");
         end
      end
      $finish;
   end

endmodule

/* dv/fetchFront_trace.txt */
# name dEn msrIe sysInt wrEn wrAddr wrData iWord | expected after the edge:
# opc rd ra imm sImm chkOp opA opB opD intAck (chkOp 0 skips the operands)
regs 0 0 0 1 01 11111111 00000000 00 00 00 0000 00000000 1 00000000 00000000 00000000 0
regs 0 0 0 1 02 22222222 00000000 00 00 00 0000 00000000 1 00000000 00000000 00000000 0
regs 0 0 0 1 03 33333333 00000000 00 00 00 0000 00000000 1 00000000 00000000 00000000 0
regs 0 0 0 1 10 16161616 00000000 00 00 00 0000 00000000 1 00000000 00000000 00000000 0
field 1 0 0 0 00 00000000 20221803 08 01 02 1803 00001803 1 22222222 33333333 11111111 0
field 1 0 0 0 00 00000000 30618007 0c 03 01 8007 ffff8007 1 11111111 16161616 33333333 0
imm 1 0 0 0 00 00000000 b000abcd 2c 00 00 abcd ffffabcd 0 00000000 00000000 00000000 0
imm 1 0 0 0 00 00000000 20411000 08 02 01 1000 abcd1000 1 11111111 22222222 22222222 0
stall 0 0 0 0 00 00000000 30618007 08 02 01 1000 abcd1000 1 11111111 22222222 22222222 0
stall 0 0 0 0 00 00000000 ffffffff 08 02 01 1000 abcd1000 1 11111111 22222222 22222222 0
stall 1 0 0 0 00 00000000 30618007 0c 03 01 8007 ffff8007 1 11111111 16161616 33333333 0
fwd 1 0 0 1 02 5a5a5a5a 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0
zero 1 0 0 1 00 deadbeef 20400800 08 02 00 0800 00000800 1 00000000 11111111 5a5a5a5a 0
int 1 1 1 0 00 00000000 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0
int 1 1 0 0 00 00000000 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0
int 1 1 0 0 00 00000000 20221803 2e 0e 0c 0060 00000060 0 00000000 00000000 00000000 1
int 1 1 0 0 00 00000000 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0
noint 1 0 1 0 00 00000000 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0
noint 1 0 0 0 00 00000000 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0
noint 1 0 0 0 00 00000000 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0
defer 1 1 1 0 00 00000000 b8000010 2e 00 00 0010 00000010 1 00000000 00000000 00000000 0
defer 1 1 0 0 00 00000000 b000abcd 2c 00 00 abcd ffffabcd 0 00000000 00000000 00000000 0
defer 1 1 0 0 00 00000000 20411000 08 02 01 1000 abcd1000 1 11111111 5a5a5a5a 5a5a5a5a 0
defer 1 1 0 0 00 00000000 20221803 2e 0e 0c 0060 00000060 0 00000000 00000000 00000000 1
defer 1 1 0 0 00 00000000 20221803 08 01 02 1803 00001803 1 5a5a5a5a 33333333 11111111 0

/* vlog.f */
hdl/isaPkg.sv
hdl/fetchPkg.sv
hdl/intLatch.sv
hdl/instBuf.sv
hdl/operandFetch.sv
hdl/fetchFront.sv
dv/tbClock.sv
dv/fetchFront_assertions.sv
dv/fetchFrontTb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetchFront testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module fetchFrontTb -Mdir obj_dir -o simv -f vlog.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Checks failed" "$LOG"; then
   exit 1
fi
exit 0
